//--- verilog/l2_bus_pkg.sv
// L2 external bus interface package
// Line geometry, queue sizing, request opcodes and the entry formats
// of the writeback and load queues

package l2_bus_pkg;

	// Memory bus and cache line geometry
	localparam int BUS_WIDTH = 32;
	localparam int LINE_BYTES = 16;
	localparam int LINE_BITS = LINE_BYTES * 8;
	localparam int BURST_BEATS = LINE_BITS / BUS_WIDTH;

	// A line address is a byte address with the offset bits stripped
	localparam int LINE_ADDR_WIDTH = 28;
	localparam int SET_INDEX_WIDTH = 4;
	localparam int TAG_WIDTH = LINE_ADDR_WIDTH - SET_INDEX_WIDTH;
	localparam int REQ_ID_WIDTH = 4;

	// Both queues have the same depth
	localparam int QUEUE_DEPTH = 8;

	// Stages ahead of this block, which may still deliver requests after a wait
	localparam int INPUT_LATENCY = 4;

	// Lines that may have a fetch in flight at once
	localparam int PENDING_ENTRIES = 4;

	typedef enum logic [2:0] {
		OP_LOAD       = 3'd0,
		OP_STORE      = 3'd1,
		OP_FLUSH      = 3'd2,
		OP_LOAD_SYNC  = 3'd3,
		OP_STORE_SYNC = 3'd4
	} l2_op_t;

	// Victim line on its way back to memory
	typedef struct packed {
		logic [LINE_ADDR_WIDTH-1:0] line_addr;
		logic [LINE_BITS-1:0]       line_data;
	} writeback_entry_t;

	// Miss waiting for a line fetch, or for a reissue only
	typedef struct packed {
		logic                       duplicate;
		l2_op_t                     op;
		logic [LINE_ADDR_WIDTH-1:0] line_addr;
		logic [LINE_BYTES-1:0]      mask;
		logic [REQ_ID_WIDTH-1:0]    id;
	} load_entry_t;

endpackage

//--- verilog/l2_request_fifo.sv
// Request FIFO
// Circular buffer of requests with an early almost-full flag, sized so
// that requests already in the pipeline still fit after it rises

`timescale 1ns/100ps

module l2_request_fifo
	#(parameter type payload_t = logic)
	(input                  clk,
	input                   reset,
	input                   push_i,
	input payload_t         push_data_i,
	input                   pop_i,
	output payload_t        head_o,
	output logic            empty_o,
	output logic            almost_full_o);

	localparam int PTR_WIDTH = $clog2(l2_bus_pkg::QUEUE_DEPTH);
	localparam int COUNT_WIDTH = $clog2(l2_bus_pkg::QUEUE_DEPTH + 1);

	payload_t storage [l2_bus_pkg::QUEUE_DEPTH];
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = count == COUNT_WIDTH'(l2_bus_pkg::QUEUE_DEPTH);
	assign empty_o = count == '0;

	// Overflow and underflow requests are dropped
	assign do_push = push_i && !full;
	assign do_pop = pop_i && !empty_o;

	// Raised once the free entries are down to the pipeline latency
	assign almost_full_o = count >= COUNT_WIDTH'(l2_bus_pkg::QUEUE_DEPTH
		- l2_bus_pkg::INPUT_LATENCY);

	assign head_o = storage[rd_ptr];

	// Each push lands in the slot under the write pointer
	always_ff @(posedge clk)
	begin
		if (do_push)
			storage[wr_ptr] <= push_data_i;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap naturally since the depth is a power of two
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;

			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;

			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end
endmodule

//--- verilog/l2_pending_miss.sv
// Pending miss tracker
// Remembers which lines have a fetch in flight so that a later miss to
// the same line can be reissued without another memory read

`timescale 1ns/100ps

module l2_pending_miss
	(input                                      clk,
	input                                       reset,
	input                                       miss_i,
	input                                       fill_i,
	input [l2_bus_pkg::LINE_ADDR_WIDTH-1:0]     line_addr_i,
	output logic                                duplicate_o);

	logic entry_valid [l2_bus_pkg::PENDING_ENTRIES];
	logic [l2_bus_pkg::LINE_ADDR_WIDTH-1:0] entry_addr [l2_bus_pkg::PENDING_ENTRIES];
	logic [l2_bus_pkg::PENDING_ENTRIES-1:0] hit;
	logic [l2_bus_pkg::PENDING_ENTRIES-1:0] alloc;

	// Match the incoming address against every live entry
	always_comb
	begin
		for (int i = 0; i < l2_bus_pkg::PENDING_ENTRIES; i++)
			hit[i] = entry_valid[i] && entry_addr[i] == line_addr_i;
	end

	assign duplicate_o = |hit;

	// Pick the lowest free slot for a new miss
	always_comb
	begin
		alloc = '0;
		for (int i = l2_bus_pkg::PENDING_ENTRIES - 1; i >= 0; i--)
		begin
			if (!entry_valid[i])
				alloc = l2_bus_pkg::PENDING_ENTRIES'(1) << i;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < l2_bus_pkg::PENDING_ENTRIES; i++)
				entry_valid[i] <= 1'b0;
		end
		else
		begin
			for (int i = 0; i < l2_bus_pkg::PENDING_ENTRIES; i++)
			begin
				// A miss already tracked does not take a second slot
				if (miss_i && !duplicate_o && alloc[i])
					entry_valid[i] <= 1'b1;
				else if (fill_i && hit[i])
					entry_valid[i] <= 1'b0;
			end
		end
	end

	// The line address is captured together with the slot allocation
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < l2_bus_pkg::PENDING_ENTRIES; i++)
		begin
			if (miss_i && !duplicate_o && alloc[i])
				entry_addr[i] <= line_addr_i;
		end
	end
endmodule

//--- verilog/l2_bus_sequencer.sv
// L2 bus sequencer
// Drains the writeback and load queues over a burst bus to memory,
// writebacks first, and hands each finished miss back as a reissue pulse

`timescale 1ns/100ps

module l2_bus_sequencer
	(input                                          clk,
	input                                           reset,

	// Queue heads
	input l2_bus_pkg::writeback_entry_t             wb_head_i,
	input                                           wb_empty_i,
	output logic                                    wb_pop_o,
	input l2_bus_pkg::load_entry_t                  ld_head_i,
	input                                           ld_empty_i,
	output logic                                    ld_pop_o,

	// Write address, data and response channels
	output logic [31:0]                             aw_addr_o,
	output logic [7:0]                              aw_len_o,
	output logic                                    aw_valid_o,
	input                                           aw_ready_i,
	output logic [l2_bus_pkg::BUS_WIDTH-1:0]        w_data_o,
	output logic                                    w_last_o,
	output logic                                    w_valid_o,
	input                                           w_ready_i,
	input                                           b_valid_i,
	output logic                                    b_ready_o,

	// Read address and data channels
	output logic [31:0]                             ar_addr_o,
	output logic [7:0]                              ar_len_o,
	output logic                                    ar_valid_o,
	input                                           ar_ready_i,
	input [l2_bus_pkg::BUS_WIDTH-1:0]               r_data_i,
	input                                           r_valid_i,
	output logic                                    r_ready_o,

	// Reissue toward the arbiter
	output logic                                    reissue_valid_o,
	output logic                                    reissue_duplicate_o,
	output l2_bus_pkg::l2_op_t                      reissue_op_o,
	output logic [l2_bus_pkg::LINE_ADDR_WIDTH-1:0]  reissue_addr_o,
	output logic [l2_bus_pkg::LINE_BYTES-1:0]       reissue_mask_o,
	output logic [l2_bus_pkg::REQ_ID_WIDTH-1:0]     reissue_id_o,
	output logic [l2_bus_pkg::LINE_BITS-1:0]        reissue_line_o);

	localparam int BEAT_WIDTH = $clog2(l2_bus_pkg::BURST_BEATS);
	localparam int OFFSET_WIDTH = $clog2(l2_bus_pkg::LINE_BYTES);
	localparam logic [BEAT_WIDTH-1:0] LAST_BEAT = BEAT_WIDTH'(l2_bus_pkg::BURST_BEATS - 1);

	typedef enum logic [2:0] {
		S_IDLE,
		S_WRITE_ADDR,
		S_WRITE_XFER,
		S_READ_ADDR,
		S_READ_XFER,
		S_COMPLETE
	} state_t;

	state_t state;
	state_t state_next;
	logic [BEAT_WIDTH-1:0] beat;
	logic [BEAT_WIDTH-1:0] beat_next;
	logic wait_b;
	logic skip_read;
	logic [l2_bus_pkg::BUS_WIDTH-1:0] load_buffer [l2_bus_pkg::BURST_BEATS];

	// Burst length encodes beats minus one
	assign aw_len_o = 8'(l2_bus_pkg::BURST_BEATS - 1);
	assign ar_len_o = 8'(l2_bus_pkg::BURST_BEATS - 1);

	// Write responses carry no errors here, so they are always taken
	assign b_ready_o = 1'b1;

	assign aw_addr_o = {wb_head_i.line_addr, OFFSET_WIDTH'(0)};
	assign ar_addr_o = {ld_head_i.line_addr, OFFSET_WIDTH'(0)};

	// Beat 0 is the lowest word of the line
	assign w_data_o = wb_head_i.line_data[beat * l2_bus_pkg::BUS_WIDTH +: l2_bus_pkg::BUS_WIDTH];

	// A duplicate was already fetched by an earlier miss, and a store
	// that writes every byte does not need the old contents at all
	assign skip_read = ld_head_i.duplicate
		|| (ld_head_i.op == l2_bus_pkg::OP_STORE && &ld_head_i.mask);

	// Reissue fields come straight off the load queue head
	assign reissue_duplicate_o = ld_head_i.duplicate;
	assign reissue_op_o = ld_head_i.op;
	assign reissue_addr_o = ld_head_i.line_addr;
	assign reissue_mask_o = ld_head_i.mask;
	assign reissue_id_o = ld_head_i.id;

	always_comb
	begin
		for (int i = 0; i < l2_bus_pkg::BURST_BEATS; i++)
			reissue_line_o[i * l2_bus_pkg::BUS_WIDTH +: l2_bus_pkg::BUS_WIDTH] = load_buffer[i];
	end

	always_comb
	begin
		state_next = state;
		beat_next = beat;
		aw_valid_o = 1'b0;
		w_valid_o = 1'b0;
		w_last_o = 1'b0;
		ar_valid_o = 1'b0;
		r_ready_o = 1'b0;
		wb_pop_o = 1'b0;
		ld_pop_o = 1'b0;
		reissue_valid_o = 1'b0;

		unique case (state)
			S_IDLE:
			begin
				// Writebacks go first so a load never reads a line that
				// is still waiting to be written back
				if (!wb_empty_i)
				begin
					if (!wait_b)
						state_next = S_WRITE_ADDR;
				end
				else if (!ld_empty_i)
				begin
					if (skip_read)
						state_next = S_COMPLETE;
					else
						state_next = S_READ_ADDR;
				end
			end

			S_WRITE_ADDR:
			begin
				aw_valid_o = 1'b1;
				beat_next = '0;
				if (aw_ready_i)
					state_next = S_WRITE_XFER;
			end

			S_WRITE_XFER:
			begin
				w_valid_o = 1'b1;
				w_last_o = beat == LAST_BEAT;
				if (w_ready_i)
				begin
					beat_next = beat + 1'b1;
					if (beat == LAST_BEAT)
					begin
						wb_pop_o = 1'b1;
						state_next = S_IDLE;
					end
				end
			end

			S_READ_ADDR:
			begin
				ar_valid_o = 1'b1;
				beat_next = '0;
				if (ar_ready_i)
					state_next = S_READ_XFER;
			end

			S_READ_XFER:
			begin
				r_ready_o = 1'b1;
				if (r_valid_i)
				begin
					beat_next = beat + 1'b1;
					if (beat == LAST_BEAT)
						state_next = S_COMPLETE;
				end
			end

			S_COMPLETE:
			begin
				// One cycle pulse, the arbiter cannot hold us off
				reissue_valid_o = 1'b1;
				ld_pop_o = 1'b1;
				state_next = S_IDLE;
			end

			default:
				state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			beat <= '0;
			wait_b <= 1'b0;
		end
		else
		begin
			state <= state_next;
			beat <= beat_next;

			// Outstanding write response, set by the address handshake
			if (state == S_WRITE_ADDR && aw_ready_i)
				wait_b <= 1'b1;
			else if (b_valid_i)
				wait_b <= 1'b0;
		end
	end

	// Each read beat lands in the slot picked by the beat counter
	always_ff @(posedge clk)
	begin
		if (state == S_READ_XFER && r_valid_i)
			load_buffer[beat] <= r_data_i;
	end
endmodule

//--- verilog/l2_bus_interface.sv
// L2 external bus interface
// Sorts read-stage results into writebacks and misses, queues them, and
// moves lines between the cache and memory through the bus sequencer

`timescale 1ns/100ps

module l2_bus_interface
	(input                                          clk,
	input                                           reset,

	// From the read stage
	input                                           rd_valid_i,
	input l2_bus_pkg::l2_op_t                       rd_op_i,
	input [l2_bus_pkg::LINE_ADDR_WIDTH-1:0]         rd_addr_i,
	input [l2_bus_pkg::LINE_BYTES-1:0]              rd_mask_i,
	input [l2_bus_pkg::REQ_ID_WIDTH-1:0]            rd_id_i,
	input                                           rd_is_fill_i,
	input                                           rd_hit_i,
	input                                           rd_dirty_i,
	input [l2_bus_pkg::TAG_WIDTH-1:0]               rd_old_tag_i,
	input [l2_bus_pkg::LINE_BITS-1:0]               rd_line_data_i,

	// Flow control and events
	output logic                                    input_wait_o,
	output logic                                    wb_event_o,

	// Memory bus
	output logic [31:0]                             aw_addr_o,
	output logic [7:0]                              aw_len_o,
	output logic                                    aw_valid_o,
	input                                           aw_ready_i,
	output logic [l2_bus_pkg::BUS_WIDTH-1:0]        w_data_o,
	output logic                                    w_last_o,
	output logic                                    w_valid_o,
	input                                           w_ready_i,
	input                                           b_valid_i,
	output logic                                    b_ready_o,
	output logic [31:0]                             ar_addr_o,
	output logic [7:0]                              ar_len_o,
	output logic                                    ar_valid_o,
	input                                           ar_ready_i,
	input [l2_bus_pkg::BUS_WIDTH-1:0]               r_data_i,
	input                                           r_valid_i,
	output logic                                    r_ready_o,

	// Reissue to the arbiter
	output logic                                    reissue_valid_o,
	output logic                                    reissue_duplicate_o,
	output l2_bus_pkg::l2_op_t                      reissue_op_o,
	output logic [l2_bus_pkg::LINE_ADDR_WIDTH-1:0]  reissue_addr_o,
	output logic [l2_bus_pkg::LINE_BYTES-1:0]       reissue_mask_o,
	output logic [l2_bus_pkg::REQ_ID_WIDTH-1:0]     reissue_id_o,
	output logic [l2_bus_pkg::LINE_BITS-1:0]        reissue_line_o);

	logic enqueue_wb;
	logic enqueue_load;
	logic duplicate;
	logic wb_empty;
	logic wb_almost_full;
	logic wb_pop;
	logic ld_empty;
	logic ld_almost_full;
	logic ld_pop;
	l2_bus_pkg::writeback_entry_t wb_entry;
	l2_bus_pkg::writeback_entry_t wb_head;
	l2_bus_pkg::load_entry_t ld_entry;
	l2_bus_pkg::load_entry_t ld_head;

	// Dirty victims are evicted by fills and by explicit flushes
	assign enqueue_wb = rd_valid_i && rd_dirty_i && (rd_op_i == l2_bus_pkg::OP_FLUSH || rd_is_fill_i);

	// Only real misses of load and store variants need a line fetch
	assign enqueue_load = rd_valid_i && !rd_hit_i && !rd_is_fill_i
		&& (rd_op_i == l2_bus_pkg::OP_LOAD || rd_op_i == l2_bus_pkg::OP_STORE
		|| rd_op_i == l2_bus_pkg::OP_LOAD_SYNC || rd_op_i == l2_bus_pkg::OP_STORE_SYNC);

	// The victim lives in the same set, under its old tag
	assign wb_entry.line_addr = {rd_old_tag_i, rd_addr_i[l2_bus_pkg::SET_INDEX_WIDTH-1:0]};
	assign wb_entry.line_data = rd_line_data_i;

	assign ld_entry.duplicate = duplicate;
	assign ld_entry.op = rd_op_i;
	assign ld_entry.line_addr = rd_addr_i;
	assign ld_entry.mask = rd_mask_i;
	assign ld_entry.id = rd_id_i;

	assign wb_event_o = enqueue_wb;

	// Hold off the pipeline early enough for in-flight requests to land
	assign input_wait_o = wb_almost_full || ld_almost_full;

	l2_request_fifo #(.payload_t(l2_bus_pkg::writeback_entry_t)) u_wb_queue (
		.clk(clk),
		.reset(reset),
		.push_i(enqueue_wb),
		.push_data_i(wb_entry),
		.pop_i(wb_pop),
		.head_o(wb_head),
		.empty_o(wb_empty),
		.almost_full_o(wb_almost_full));

	l2_request_fifo #(.payload_t(l2_bus_pkg::load_entry_t)) u_load_queue (
		.clk(clk),
		.reset(reset),
		.push_i(enqueue_load),
		.push_data_i(ld_entry),
		.pop_i(ld_pop),
		.head_o(ld_head),
		.empty_o(ld_empty),
		.almost_full_o(ld_almost_full));

	// A fill coming back through the pipeline retires the tracked line
	l2_pending_miss u_pending_miss (
		.clk(clk),
		.reset(reset),
		.miss_i(enqueue_load),
		.fill_i(rd_valid_i && rd_is_fill_i),
		.line_addr_i(rd_addr_i),
		.duplicate_o(duplicate));

	l2_bus_sequencer u_sequencer (
		.clk(clk),
		.reset(reset),
		.wb_head_i(wb_head),
		.wb_empty_i(wb_empty),
		.wb_pop_o(wb_pop),
		.ld_head_i(ld_head),
		.ld_empty_i(ld_empty),
		.ld_pop_o(ld_pop),
		.aw_addr_o(aw_addr_o),
		.aw_len_o(aw_len_o),
		.aw_valid_o(aw_valid_o),
		.aw_ready_i(aw_ready_i),
		.w_data_o(w_data_o),
		.w_last_o(w_last_o),
		.w_valid_o(w_valid_o),
		.w_ready_i(w_ready_i),
		.b_valid_i(b_valid_i),
		.b_ready_o(b_ready_o),
		.ar_addr_o(ar_addr_o),
		.ar_len_o(ar_len_o),
		.ar_valid_o(ar_valid_o),
		.ar_ready_i(ar_ready_i),
		.r_data_i(r_data_i),
		.r_valid_i(r_valid_i),
		.r_ready_o(r_ready_o),
		.reissue_valid_o(reissue_valid_o),
		.reissue_duplicate_o(reissue_duplicate_o),
		.reissue_op_o(reissue_op_o),
		.reissue_addr_o(reissue_addr_o),
		.reissue_mask_o(reissue_mask_o),
		.reissue_id_o(reissue_id_o),
		.reissue_line_o(reissue_line_o));
endmodule

//--- testbench/l2_bus_interface_tb.sv
// Testbench for the L2 external bus interface
// Plays the read stage and a burst memory with random handshake delays,
// and checks bursts, reissues and flow control against the vector file

`timescale 1ns/100ps

module l2_bus_interface_tb;

	localparam int MAX_ROWS = 64;
	localparam int ROW_BITS = 220;
	localparam int MEM_LINES = 256;
	localparam int BW = l2_bus_pkg::BUS_WIDTH;

	// Expected reissue, built when the request is presented
	typedef struct packed {
		logic                                   check_line;
		logic                                   duplicate;
		logic [2:0]                             op;
		logic [l2_bus_pkg::REQ_ID_WIDTH-1:0]    id;
		logic [l2_bus_pkg::LINE_BYTES-1:0]      mask;
		logic [l2_bus_pkg::LINE_ADDR_WIDTH-1:0] line_addr;
		logic [l2_bus_pkg::LINE_BITS-1:0]       line;
	} reissue_t;

	logic clk;
	logic reset;
	logic rd_valid_i;
	l2_bus_pkg::l2_op_t rd_op_i;
	logic [l2_bus_pkg::LINE_ADDR_WIDTH-1:0] rd_addr_i;
	logic [l2_bus_pkg::LINE_BYTES-1:0] rd_mask_i;
	logic [l2_bus_pkg::REQ_ID_WIDTH-1:0] rd_id_i;
	logic rd_is_fill_i;
	logic rd_hit_i;
	logic rd_dirty_i;
	logic [l2_bus_pkg::TAG_WIDTH-1:0] rd_old_tag_i;
	logic [l2_bus_pkg::LINE_BITS-1:0] rd_line_data_i;
	logic input_wait_o;
	logic wb_event_o;
	logic [31:0] aw_addr_o;
	logic [7:0] aw_len_o;
	logic aw_valid_o;
	logic aw_ready_i;
	logic [BW-1:0] w_data_o;
	logic w_last_o;
	logic w_valid_o;
	logic w_ready_i;
	logic b_valid_i;
	logic b_ready_o;
	logic [31:0] ar_addr_o;
	logic [7:0] ar_len_o;
	logic ar_valid_o;
	logic ar_ready_i;
	logic [BW-1:0] r_data_i;
	logic r_valid_i;
	logic r_ready_o;
	logic reissue_valid_o;
	logic reissue_duplicate_o;
	l2_bus_pkg::l2_op_t reissue_op_o;
	logic [l2_bus_pkg::LINE_ADDR_WIDTH-1:0] reissue_addr_o;
	logic [l2_bus_pkg::LINE_BYTES-1:0] reissue_mask_o;
	logic [l2_bus_pkg::REQ_ID_WIDTH-1:0] reissue_id_o;
	logic [l2_bus_pkg::LINE_BITS-1:0] reissue_line_o;

	logic [ROW_BITS-1:0] rows [MAX_ROWS];
	logic [BW-1:0] mem [MEM_LINES * l2_bus_pkg::BURST_BEATS];
	logic [l2_bus_pkg::LINE_BITS-1:0] ref_line [MEM_LINES];
	logic [31:0] exp_aw_addr [$];
	logic [l2_bus_pkg::LINE_BITS-1:0] exp_w_data [$];
	logic [31:0] exp_ar_addr [$];
	reissue_t exp_reissue [$];
	logic [l2_bus_pkg::LINE_ADDR_WIDTH-1:0] fill_lines [$];
	logic bus_stall = 1'b0;
	int errors = 0;
	int wb_events = 0;
	int cycles = 0;
	int timeout_limit = 0;
	int tests_run = 0;
	int tests_failed = 0;

	l2_bus_interface u_l2_bus_interface (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	task automatic compare(input string name, input logic [l2_bus_pkg::LINE_BITS-1:0] got,
		input logic [l2_bus_pkg::LINE_BITS-1:0] expected);
		if (got !== expected)
		begin
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic drive_idle();
		rd_valid_i = 1'b0;
		rd_op_i = l2_bus_pkg::OP_LOAD;
		rd_addr_i = '0;
		rd_mask_i = '0;
		rd_id_i = '0;
		rd_is_fill_i = 1'b0;
		rd_hit_i = 1'b0;
		rd_dirty_i = 1'b0;
		rd_old_tag_i = '0;
		rd_line_data_i = '0;
	endtask

	// A clean fill, as the pipeline sends once the reissued line is written
	task automatic drive_fill(input logic [l2_bus_pkg::LINE_ADDR_WIDTH-1:0] line_addr);
		drive_idle();
		rd_valid_i = 1'b1;
		rd_is_fill_i = 1'b1;
		rd_addr_i = line_addr;
	endtask

	// Drives one vector row and queues what the DUT must do with it
	task automatic present_row(input logic [ROW_BITS-1:0] row);
		logic [l2_bus_pkg::LINE_ADDR_WIDTH-1:0] wb_line;
		logic [3:0] cls;
		reissue_t ri;
		cls = row[211:208];
		rd_valid_i = 1'b1;
		rd_op_i = l2_bus_pkg::l2_op_t'(row[206:204]);
		rd_is_fill_i = row[202];
		rd_hit_i = row[201];
		rd_dirty_i = row[200];
		rd_id_i = row[199:196];
		rd_mask_i = row[195:180];
		rd_addr_i = row[179:152];
		rd_old_tag_i = row[151:128];
		rd_line_data_i = row[127:0];
		ri = '0;
		ri.op = row[206:204];
		ri.id = rd_id_i;
		ri.mask = rd_mask_i;
		ri.line_addr = rd_addr_i;
		case (cls)
			4'd2:
			begin
				// Victim goes back under its old tag in the same set
				wb_line = {rd_old_tag_i, rd_addr_i[l2_bus_pkg::SET_INDEX_WIDTH-1:0]};
				exp_aw_addr.push_back({wb_line, 4'h0});
				exp_w_data.push_back(rd_line_data_i);
				ref_line[wb_line[7:0]] = rd_line_data_i;
			end
			4'd1, 4'd5:
			begin
				exp_ar_addr.push_back({rd_addr_i, 4'h0});
				ri.check_line = 1'b1;
				ri.line = ref_line[rd_addr_i[7:0]];
				exp_reissue.push_back(ri);
			end
			4'd3:
			begin
				ri.duplicate = 1'b1;
				exp_reissue.push_back(ri);
			end
			4'd4:
				exp_reissue.push_back(ri);
			default:
			begin
				$display("Vector row has an unknown result class %0d", cls);
				errors++;
			end
		endcase
	endtask

	task automatic run_test(input int first, input int last);
		int err_start;
		int wb_start;
		int wb_expected;
		int test_num;
		logic stall;
		logic done;
		err_start = errors;
		wb_start = wb_events;
		wb_expected = 0;
		test_num = rows[first][219:212];
		stall = 1'b0;
		for (int k = first; k < last; k++)
		begin
			if (rows[k][211:208] == 4'd5)
				stall = 1'b1;
			if (rows[k][211:208] == 4'd2)
				wb_expected++;
		end
		// The bus is held off from a rising edge so the memory model sees a stable flag
		if (stall)
		begin
			@(posedge clk);
			bus_stall = 1'b1;
		end
		for (int k = first; k < last; k++)
		begin
			@(negedge clk);
			// With the bus stalled nothing leaves the queue
			if (stall)
				compare("input_wait_o", input_wait_o, (k - first) >=
					l2_bus_pkg::QUEUE_DEPTH - l2_bus_pkg::INPUT_LATENCY);
			present_row(rows[k]);
		end
		@(negedge clk);
		drive_idle();
		if (stall)
		begin
			compare("input_wait_o", input_wait_o, (last - first) >=
				l2_bus_pkg::QUEUE_DEPTH - l2_bus_pkg::INPUT_LATENCY);
			repeat (4)
				@(negedge clk);
			@(posedge clk);
			bus_stall = 1'b0;
		end
		done = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			if (fill_lines.size() > 0)
				drive_fill(fill_lines.pop_front());
			else
			begin
				drive_idle();
				done = exp_aw_addr.size() == 0 && exp_ar_addr.size() == 0
					&& exp_reissue.size() == 0;
			end
		end
		compare("wb_event_o count", wb_events - wb_start, wb_expected);
		tests_run++;
		if (errors != err_start)
			tests_failed++;
		$display("Test %0d %s, %0d errors", test_num,
			(errors == err_start) ? "ok" : "with mismatches", errors - err_start);
	endtask

	// Memory side of the bus, sampled on rising edges and driven on falling edges
	initial
	begin
		int aw_delay;
		int w_delay;
		int b_delay;
		int ar_delay;
		int r_delay;
		int wr_beat;
		int rd_beat;
		logic [7:0] wr_line;
		logic [7:0] rd_line;
		logic [l2_bus_pkg::LINE_BITS-1:0] wr_expect;
		logic b_pending;
		logic rd_active;
		void'($urandom(32'h72f2f593));
		aw_ready_i = 1'b0;
		w_ready_i = 1'b0;
		b_valid_i = 1'b0;
		ar_ready_i = 1'b0;
		r_valid_i = 1'b0;
		r_data_i = '0;
		// Every word starts out holding its own byte address
		for (int i = 0; i < MEM_LINES * l2_bus_pkg::BURST_BEATS; i++)
			mem[i] = 32'(i * 4);
		aw_delay = $urandom % 4;
		w_delay = $urandom % 4;
		b_delay = 0;
		ar_delay = $urandom % 4;
		r_delay = $urandom % 4;
		wr_beat = 0;
		rd_beat = 0;
		wr_line = '0;
		rd_line = '0;
		wr_expect = '0;
		b_pending = 1'b0;
		rd_active = 1'b0;
		forever
		begin
			@(posedge clk);
			// A new write address must wait for the previous response
			if (aw_valid_o && aw_ready_i && b_pending)
			begin
				$display("Write address at %0t while a write response was outstanding",
					$time);
				errors++;
			end
			if (b_valid_i)
			begin
				compare("b_ready_o", b_ready_o, 1'b1);
				b_pending = 1'b0;
			end
			if (aw_valid_o && aw_ready_i)
			begin
				if (exp_aw_addr.size() == 0)
				begin
					$display("Write burst to %0h at %0t that no request asked for",
						aw_addr_o, $time);
					errors++;
					wr_expect = '0;
				end
				else
				begin
					compare("aw_addr_o", aw_addr_o, exp_aw_addr.pop_front());
					wr_expect = exp_w_data.pop_front();
				end
				compare("aw_len_o", aw_len_o, l2_bus_pkg::BURST_BEATS - 1);
				wr_line = aw_addr_o[11:4];
				wr_beat = 0;
				aw_delay = $urandom % 4;
			end
			if (w_valid_o && w_ready_i)
			begin
				mem[int'(wr_line) * l2_bus_pkg::BURST_BEATS + wr_beat] = w_data_o;
				compare("w_data_o", w_data_o, wr_expect[wr_beat * BW +: BW]);
				compare("w_last_o", w_last_o, wr_beat == l2_bus_pkg::BURST_BEATS - 1);
				if (wr_beat == l2_bus_pkg::BURST_BEATS - 1)
				begin
					b_pending = 1'b1;
					b_delay = $urandom % 4;
				end
				wr_beat++;
				w_delay = $urandom % 4;
			end
			if (ar_valid_o && ar_ready_i)
			begin
				// Queued writebacks must drain before any line fetch
				if (exp_w_data.size() > 0)
				begin
					$display("Read burst at %0t while a writeback was still queued", $time);
					errors++;
				end
				if (exp_ar_addr.size() == 0)
				begin
					$display("Read burst from %0h at %0t that no miss needed",
						ar_addr_o, $time);
					errors++;
				end
				else
					compare("ar_addr_o", ar_addr_o, exp_ar_addr.pop_front());
				compare("ar_len_o", ar_len_o, l2_bus_pkg::BURST_BEATS - 1);
				rd_line = ar_addr_o[11:4];
				rd_beat = 0;
				rd_active = 1'b1;
				ar_delay = $urandom % 4;
			end
			if (r_valid_i && r_ready_o)
			begin
				rd_beat++;
				if (rd_beat == l2_bus_pkg::BURST_BEATS)
					rd_active = 1'b0;
				r_delay = $urandom % 4;
			end

			@(negedge clk);
			aw_ready_i = !bus_stall && aw_delay == 0;
			if (!bus_stall && aw_valid_o && aw_delay > 0)
				aw_delay--;
			w_ready_i = !bus_stall && w_delay == 0;
			if (!bus_stall && w_valid_o && w_delay > 0)
				w_delay--;
			ar_ready_i = !bus_stall && ar_delay == 0;
			if (!bus_stall && ar_valid_o && ar_delay > 0)
				ar_delay--;
			b_valid_i = !bus_stall && b_pending && b_delay == 0;
			if (!bus_stall && b_pending && b_delay > 0)
				b_delay--;
			r_valid_i = !bus_stall && rd_active && r_delay == 0;
			if (rd_active)
				r_data_i = mem[int'(rd_line) * l2_bus_pkg::BURST_BEATS + rd_beat];
			if (!bus_stall && rd_active && r_delay > 0)
				r_delay--;
		end
	end

	// Arbiter side, takes each reissue and asks the driver for a fill
	initial
	begin
		reissue_t expected;
		forever
		begin
			@(posedge clk);
			if (wb_event_o)
				wb_events++;
			if (reissue_valid_o)
			begin
				if (exp_reissue.size() == 0)
				begin
					$display("Reissue of line %0h at %0t with no request waiting for it",
						reissue_addr_o, $time);
					errors++;
				end
				else
				begin
					expected = exp_reissue.pop_front();
					compare("reissue_addr_o", reissue_addr_o, expected.line_addr);
					compare("reissue_op_o", reissue_op_o, expected.op);
					compare("reissue_mask_o", reissue_mask_o, expected.mask);
					compare("reissue_id_o", reissue_id_o, expected.id);
					compare("reissue_duplicate_o", reissue_duplicate_o, expected.duplicate);
					if (expected.check_line)
						compare("reissue_line_o", reissue_line_o, expected.line);
				end
				fill_lines.push_back(reissue_addr_o);
			end
		end
	end

	initial
	begin
		wait (timeout_limit > 0);
		while (cycles < timeout_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped after %0d cycles before all tests finished", cycles);
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		int row_count;
		int first;
		int r;
		reset = 1'b1;
		drive_idle();
		for (int l = 0; l < MEM_LINES; l++)
		begin
			for (int b = 0; b < l2_bus_pkg::BURST_BEATS; b++)
				ref_line[l][b * BW +: BW] = 32'((l * l2_bus_pkg::BURST_BEATS + b) * 4);
		end
		for (int i = 0; i < MAX_ROWS; i++)
			rows[i] = '0;
		$readmemh("testbench/l2_bus_interface_vectors.txt", rows);
		// Test number zero marks the end of the table
		row_count = 0;
		while (row_count < MAX_ROWS && rows[row_count][219:212] != 8'h00)
			row_count++;
		if (row_count == 0)
		begin
			$display("No vector rows could be read");
			errors++;
		end
		timeout_limit = row_count * 200;

		repeat (2)
			@(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		compare("outputs after reset", {aw_valid_o, w_valid_o, w_last_o, ar_valid_o,
			r_ready_o, reissue_valid_o, input_wait_o, wb_event_o}, 8'h00);

		r = 0;
		while (r < row_count)
		begin
			first = r;
			while (r < row_count && rows[r][219:212] == rows[first][219:212])
				r++;
			run_test(first, r);
		end

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end
endmodule

//--- testbench/l2_bus_interface_vectors.txt
// test_class_op_flags(fill,hit,dirty)_id_mask_lineaddr_oldtag_data(word3..word0)
// class 1 miss read, 2 writeback, 3 duplicate miss, 4 full line store, 5 miss with bus held off
// Load miss
01_1_0_0_1_000f_0000010_000000_00000000_00000000_00000000_00000000
// Dirty fill, then a dirty flush
02_2_0_5_0_0000_0000031_000004_11111111_22222222_33333333_44444444
02_2_2_3_0_0000_0000052_000006_a5a5a5a5_5a5a5a5a_0f0f0f0f_f0f0f0f0
// Second miss to a line still being fetched
03_1_3_0_2_00f0_0000020_000000_00000000_00000000_00000000_00000000
03_3_1_0_3_0f00_0000020_000000_00000000_00000000_00000000_00000000
// Store covering the whole line
04_4_1_0_4_ffff_0000030_000000_00000000_00000000_00000000_00000000
// Writeback of line 23, then a miss that reads it back
05_2_0_5_0_0000_0000053_000002_deadbeef_cafef00d_01234567_89abcdef
05_1_0_0_5_00ff_0000023_000000_00000000_00000000_00000000_00000000
// Eight misses while the bus is stalled
06_5_0_0_8_0001_0000080_000000_00000000_00000000_00000000_00000000
06_5_1_0_9_0003_0000081_000000_00000000_00000000_00000000_00000000
06_5_3_0_a_000f_0000082_000000_00000000_00000000_00000000_00000000
06_5_4_0_b_00f0_0000083_000000_00000000_00000000_00000000_00000000
06_5_0_0_c_0f00_0000084_000000_00000000_00000000_00000000_00000000
06_5_1_0_d_f000_0000085_000000_00000000_00000000_00000000_00000000
06_5_3_0_e_00ff_0000086_000000_00000000_00000000_00000000_00000000
06_5_4_0_f_ff00_0000087_000000_00000000_00000000_00000000_00000000

//--- l2_bus_interface.f
verilog/l2_bus_pkg.sv
verilog/l2_request_fifo.sv
verilog/l2_pending_miss.sv
verilog/l2_bus_sequencer.sv
verilog/l2_bus_interface.sv
testbench/l2_bus_interface_tb.sv

//--- Bender.yml
package:
  name: l2_bus_interface

sources:
  - verilog/l2_bus_pkg.sv
  - verilog/l2_request_fifo.sv
  - verilog/l2_pending_miss.sv
  - verilog/l2_bus_sequencer.sv
  - verilog/l2_bus_interface.sv
  - target: test
    files:
      - testbench/l2_bus_interface_tb.sv
